// ==== common/frontendPkg.sv ====
package frontendPkg;

	// datapath widths
	localparam int XLEN = 32;        // pc and instruction word
	localparam int IMEM_DEPTH = 256; // words in the instruction memory
	localparam int IMEM_AW = 8;      // memory index width, log2 of IMEM_DEPTH

	// fetch queue geometry, depth must stay a power of two
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_AW = 2;

	// next-pc choice
	typedef enum logic [1:0] {
		pcSeq    = 2'd0, // pc + 1, also means no redirect
		pcZero   = 2'd1, // restart at address zero
		pcTarget = 2'd2, // jump to redirect target
		pcHold   = 2'd3  // keep the pc, no issue
	} pcSel_e;

	// redirect command from outside the front end
	typedef struct packed {
		pcSel_e          sel;
		logic [XLEN-1:0] target;
	} redirectReq_t;

	// one program word on the load port
	typedef struct packed {
		logic [IMEM_AW-1:0] addr;
		logic [XLEN-1:0]    data;
		logic               last; // final word of the program
	} loadWord_t;

	// loader write into the instruction memory
	typedef struct packed {
		logic               en;
		logic [IMEM_AW-1:0] addr;
		logic [XLEN-1:0]    data;
	} memWrite_t;

	// one fetched instruction toward decode
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr; // zero when fault is set
		logic            fault; // pc outside the memory
	} fetchPacket_t;

endpackage

// ==== design/fetchQueue.sv ====
`timescale 1ns/1ps

module fetchQueue (
	input  logic                         clk,
	input  logic                         nrst,
	input  logic                         flush,
	input  frontendPkg::fetchPacket_t    inPkt,
	input  logic                         inValid,
	output logic                         credit,
	output frontendPkg::fetchPacket_t    outPkt,
	output logic                         outValid,
	input  logic                         outReady
);

	frontendPkg::fetchPacket_t entries [frontendPkg::QUEUE_DEPTH];

	logic [frontendPkg::QUEUE_AW-1:0] wrPtr;
	logic [frontendPkg::QUEUE_AW-1:0] rdPtr;
	logic [frontendPkg::QUEUE_AW:0]   count; // one extra bit to hold a full queue
	logic                             push;
	logic                             pop;

	// a flushed cycle neither stores nor hands out a packet
	assign push = inValid && !flush;
	assign pop = outValid && outReady && !flush;

	assign outValid = (count != '0);
	assign outPkt = entries[rdPtr];

	// two free slots cover the word in flight plus a new issue
	assign credit = (count <= frontendPkg::QUEUE_DEPTH - 2);

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10:
					count <= count + 1'b1;
				2'b01:
					count <= count - 1'b1;
				default:
					count <= count; // idle, or push and pop together
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			entries[wrPtr] <= inPkt;
	end

	// the credit handshake with the fetch stage must keep pushes off a full queue
	noPushWhenFull: assert property (
		@(posedge clk) disable iff (!nrst) push |-> (count < frontendPkg::QUEUE_DEPTH)
	);

endmodule

// ==== design/frontendTop.sv ====
`timescale 1ns/1ps

module frontendTop (
	input  logic                         clk,
	input  logic                         nrst,
	input  frontendPkg::loadWord_t       loadIn,
	input  logic                         loadValid,
	output logic                         loadReady,
	input  frontendPkg::redirectReq_t    redirect,
	output frontendPkg::fetchPacket_t    decOut,
	output logic                         decValid,
	input  logic                         decReady
);

	frontendPkg::memWrite_t    memWrite;
	frontendPkg::fetchPacket_t fetchPkt;
	logic                      halt;
	logic                      restart;
	logic                      fetchValid;
	logic                      flush;
	logic                      credit; // queue room back to the pc

	programLoader uLoader (
		.clk       (clk),
		.nrst      (nrst),
		.loadIn    (loadIn),
		.loadValid (loadValid),
		.loadReady (loadReady),
		.memWrite  (memWrite),
		.halt      (halt),
		.restart   (restart)
	);

	fetchStage uFetch (
		.clk        (clk),
		.nrst       (nrst),
		.redirect   (redirect),
		.restart    (restart),
		.halt       (halt),
		.credit     (credit),
		.memWrite   (memWrite),
		.fetchPkt   (fetchPkt),
		.fetchValid (fetchValid),
		.flush      (flush)
	);

	// decode side handshake
	fetchQueue uQueue (
		.clk      (clk),
		.nrst     (nrst),
		.flush    (flush),
		.inPkt    (fetchPkt),
		.inValid  (fetchValid),
		.credit   (credit),
		.outPkt   (decOut),
		.outValid (decValid),
		.outReady (decReady)
	);

endmodule

// ==== design/programLoader.sv ====
`timescale 1ns/1ps

module programLoader (
	input  logic                      clk,
	input  logic                      nrst,
	input  frontendPkg::loadWord_t    loadIn,
	input  logic                      loadValid,
	output logic                      loadReady,
	output frontendPkg::memWrite_t    memWrite,
	output logic                      halt,
	output logic                      restart
);

	logic accept;

	// one bubble on the load port while restart goes out
	assign loadReady = !restart;
	assign accept = loadValid && loadReady;

	// accepted words go straight into memory on the same edge
	always_comb
	begin
		memWrite.en = accept;
		memWrite.addr = loadIn.addr;
		memWrite.data = loadIn.data;
	end

	// halt marks an open program load
	// it opens on the first word and closes as restart fires
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			halt <= 1'b0;
			restart <= 1'b0;
		end
		else
		begin
			restart <= accept && loadIn.last;
			if (accept)
				halt <= !loadIn.last; // last word closes the load
		end
	end

	// restart is a single-cycle pulse into the fetch stage
	restartPulse: assert property (
		@(posedge clk) disable iff (!nrst) restart |=> !restart
	);

endmodule

// ==== fetchStage/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage (
	input  logic                         clk,
	input  logic                         nrst,
	input  frontendPkg::redirectReq_t    redirect,
	input  logic                         restart,
	input  logic                         halt,
	input  logic                         credit,
	input  frontendPkg::memWrite_t       memWrite,
	output frontendPkg::fetchPacket_t    fetchPkt,
	output logic                         fetchValid,
	output logic                         flush
);

	logic [frontendPkg::XLEN-1:0] pcReg;      // next address to issue
	logic [frontendPkg::XLEN-1:0] nextPc;
	logic [frontendPkg::XLEN-1:0] inFlightPc; // pc of the word the memory is reading
	logic [frontendPkg::XLEN-1:0] rdData;
	logic                         redirectTaken;
	logic                         issue;
	logic                         inFlight;
	logic                         addrFault;

	// pcZero and pcTarget both throw away everything fetched so far
	assign redirectTaken = (redirect.sel == frontendPkg::pcZero) ||
		(redirect.sel == frontendPkg::pcTarget);
	assign flush = restart || redirectTaken;

	// issue only with room for both the in-flight word and this one
	assign issue = credit && !halt && !flush && (redirect.sel != frontendPkg::pcHold);

	always_comb
	begin
		if (restart)
			nextPc = '0; // loader restart wins over any redirect
		else
		begin
			case (redirect.sel)
				frontendPkg::pcZero:
					nextPc = '0;
				frontendPkg::pcTarget:
					nextPc = redirect.target;
				default:
					nextPc = issue ? pcReg + 1'b1 : pcReg; // pcSeq or pcHold
			endcase
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			pcReg <= '0;
		else
			pcReg <= nextPc;
	end

	// at most one word in flight
	// flush cycles never issue, so a flushed word is not followed by another
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			inFlight <= 1'b0;
		else
			inFlight <= issue;
	end

	always_ff @(posedge clk)
	begin
		if (issue)
			inFlightPc <= pcReg;
	end

	// only the low bits reach the memory, out of range pcs are caught below
	instrMem uMem (
		.clk    (clk),
		.rdAddr (pcReg[frontendPkg::IMEM_AW-1:0]),
		.rdData (rdData),
		.wr     (memWrite)
	);

	assign addrFault = (inFlightPc >= frontendPkg::IMEM_DEPTH);

	always_comb
	begin
		fetchPkt.pc = inFlightPc;
		fetchPkt.instr = addrFault ? '0 : rdData; // no aliased word on a fault
		fetchPkt.fault = addrFault;
	end

	// word returns one clock after issue
	assign fetchValid = inFlight;

	// a discarded word must not surface once the flush edge has passed
	noValidAfterFlush: assert property (
		@(posedge clk) disable iff (!nrst) flush |=> !fetchValid
	);

endmodule

// ==== fetchStage/instrMem.sv ====
`timescale 1ns/1ps

// single read port, single write port word memory
// read data appears one clock after the address
module instrMem (
	input  logic                             clk,
	input  logic [frontendPkg::IMEM_AW-1:0] rdAddr,
	output logic [frontendPkg::XLEN-1:0]    rdData,
	input  frontendPkg::memWrite_t           wr
);

	logic [frontendPkg::XLEN-1:0] mem [frontendPkg::IMEM_DEPTH];

	// write port, driven by the program loader
	always_ff @(posedge clk)
	begin
		if (wr.en)
			mem[wr.addr] <= wr.data;
	end

	// registered read
	// a write to the same address on this edge is not seen yet
	always_ff @(posedge clk)
	begin
		rdData <= mem[rdAddr]; // old data on collision
	end

endmodule

// ==== list.f ====
+incdir+verification
common/frontendPkg.sv
fetchStage/instrMem.sv
fetchStage/fetchStage.sv
design/programLoader.sv
design/fetchQueue.sv
design/frontendTop.sv
verification/frontendTb.sv

// ==== verification/frontendModel.svh ====
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// mirror of the instruction memory as the testbench loaded it
logic [frontendPkg::XLEN-1:0] modelMem [frontendPkg::IMEM_DEPTH];

// program words waiting for the load port
frontendPkg::loadWord_t progWords [frontendPkg::IMEM_DEPTH];

logic [frontendPkg::XLEN-1:0] expPc; // pc decode should see next

// random program at addresses 0 up to len-1
task automatic buildProgram(input int len);
	int i;
	logic [31:0] idx;
	for (i = 0; i < len; i++)
	begin
		idx = i;
		progWords[i].addr = idx[frontendPkg::IMEM_AW-1:0];
		progWords[i].data = $urandom;
		progWords[i].last = (i == len - 1); // final word closes the load
	end
endtask

// the new contents count only from the restart on
task automatic commitProgram(input int len);
	int i;
	for (i = 0; i < len; i++)
		modelMem[progWords[i].addr] = progWords[i].data;
endtask

// what a correct front end hands out for a given pc
function automatic frontendPkg::fetchPacket_t expectedPacket(
	input logic [frontendPkg::XLEN-1:0] pc);
	frontendPkg::fetchPacket_t p;
	p.pc = pc;
	if (pc < frontendPkg::IMEM_DEPTH)
	begin
		p.instr = modelMem[pc[frontendPkg::IMEM_AW-1:0]];
		p.fault = 1'b0;
	end
	else
	begin
		p.instr = '0; // outside the memory
		p.fault = 1'b1;
	end
	return p;
endfunction

`endif

// ==== verification/frontendTb.sv ====
`timescale 1ns/1ps

module frontendTb;

	logic                      clk;
	logic                      nrst;
	frontendPkg::loadWord_t    loadIn;
	logic                      loadValid;
	logic                      loadReady;
	frontendPkg::redirectReq_t redirect;
	frontendPkg::fetchPacket_t decOut;
	logic                      decValid;
	logic                      decReady;

	`include "frontendModel.svh"

	int rdyLowPct;       // percent of cycles decode stalls
	bit checking;        // off while the memory still holds unknown words
	bit loading;
	bit loadRandValid;
	bit restartNext;     // restart pulse due in the coming cycle
	bit haltSeen;
	bit firstAfterLoad;
	int loadIdx;
	int loadLen;
	int delivered;
	int deliveredInLoad;
	int seedDummy;

	frontendTop dut_i (
		.clk       (clk),
		.nrst      (nrst),
		.loadIn    (loadIn),
		.loadValid (loadValid),
		.loadReady (loadReady),
		.redirect  (redirect),
		.decOut    (decOut),
		.decValid  (decValid),
		.decReady  (decReady)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic reportError(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkPacket(input frontendPkg::fetchPacket_t got,
		input frontendPkg::fetchPacket_t exp);
		if (got !== exp)
			reportError($sformatf(
				"ERR %0t: packet pc %0h instr %h fault %b, expected pc %0h instr %h fault %b",
				$time, got.pc, got.instr, got.fault, exp.pc, exp.instr, exp.fault));
	endtask

	// first packet once a load has closed and restart went out
	task automatic checkLoadDone(input frontendPkg::fetchPacket_t got,
		input frontendPkg::fetchPacket_t exp);
		if (got.pc !== '0)
			reportError($sformatf("ERR %0t: first packet after load has pc %0h, expected 0",
				$time, got.pc));
		else if (got !== exp)
			reportError($sformatf(
				"ERR %0t: first packet after load instr %h fault %b, expected instr %h fault %b",
				$time, got.instr, got.fault, exp.instr, exp.fault));
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
			reportError($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	function automatic frontendPkg::redirectReq_t makeRedirect(
		input frontendPkg::pcSel_e sel, input logic [frontendPkg::XLEN-1:0] target);
		frontendPkg::redirectReq_t r;
		r.sel = sel;
		r.target = target;
		return r;
	endfunction

	// one clock with inputs driven at +1 ns and outputs sampled at +3 ns
	task automatic runCycle(input frontendPkg::redirectReq_t redir, input bit stall);
		bit restartNow;
		frontendPkg::fetchPacket_t exp;
		@(posedge clk);
		#1;
		restartNow = restartNext;
		restartNext = 1'b0;
		redirect = redir;
		decReady = (stall || restartNow) ? 1'b0 : (($urandom % 100) >= rdyLowPct);
		if (loading)
		begin
			loadIn = progWords[loadIdx];
			loadValid = loadRandValid ? (($urandom % 2) == 1) : 1'b1;
		end
		else
			loadValid = 1'b0;
		#2;
		if (decValid === 1'b1 && decReady && checking)
		begin
			exp = expectedPacket(expPc);
			if (firstAfterLoad)
				checkLoadDone(decOut, exp);
			else
				checkPacket(decOut, exp);
			firstAfterLoad = 1'b0;
			expPc = expPc + 1'b1;
			delivered++;
			if (haltSeen)
				deliveredInLoad++; // only words fetched before the halt may drain
		end
		if (loadValid && loadReady === 1'b1)
		begin
			haltSeen = 1'b1;
			loadIdx++;
			if (loadIn.last)
			begin
				loading = 1'b0;
				restartNext = 1'b1;
			end
		end
		if (restartNow)
		begin
			checkFlag(loadReady, 1'b0, "loadReady in the restart cycle");
			if (deliveredInLoad > frontendPkg::QUEUE_DEPTH)
				reportError($sformatf("ERR %0t: %0d packets delivered during a load, at most %0d",
					$time, deliveredInLoad, frontendPkg::QUEUE_DEPTH));
			commitProgram(loadLen);
			expPc = '0;
			checking = 1'b1;
			firstAfterLoad = 1'b1;
			haltSeen = 1'b0;
		end
		if (redir.sel == frontendPkg::pcZero)
			expPc = '0;
		else if (redir.sel == frontendPkg::pcTarget)
			expPc = redir.target;
	endtask

	task automatic consumePackets(input int n, input int timeout, input string what);
		int goal;
		int cycles;
		goal = delivered + n;
		cycles = 0;
		while (delivered < goal)
		begin
			if (cycles == timeout)
				reportError($sformatf("timed out after %0d cycles waiting for %s", timeout, what));
			runCycle(makeRedirect(frontendPkg::pcSeq, '0), 1'b0);
			cycles++;
		end
	endtask

	// runs until the restart cycle after the last word has passed
	task automatic loadProgram(input int len, input bit randValid, input int timeout);
		int cycles;
		buildProgram(len);
		loadLen = len;
		loadIdx = 0;
		loadRandValid = randValid;
		deliveredInLoad = 0;
		loading = 1'b1;
		cycles = 0;
		while (loading || restartNext)
		begin
			if (cycles == timeout)
				reportError($sformatf("timed out after %0d cycles loading a program", timeout));
			runCycle(makeRedirect(frontendPkg::pcSeq, '0), 1'b0);
			cycles++;
		end
	endtask

	// redirects go out with decode stalled
	task automatic applyRedirect(input frontendPkg::pcSel_e sel,
		input logic [frontendPkg::XLEN-1:0] target);
		runCycle(makeRedirect(sel, target), 1'b1);
	endtask

	task automatic holdFetch(input int n);
		int i;
		for (i = 0; i < n; i++)
			runCycle(makeRedirect(frontendPkg::pcHold, '0), 1'b0);
	endtask

	initial
	begin
		seedDummy = $urandom(42755);
		nrst = 1'b0;
		loadIn = '0;
		loadValid = 1'b0;
		redirect = makeRedirect(frontendPkg::pcSeq, '0);
		decReady = 1'b0;
		rdyLowPct = 100; // decode parked until the first program is in
		checking = 1'b0;
		loading = 1'b0;
		loadRandValid = 1'b0;
		restartNext = 1'b0;
		haltSeen = 1'b0;
		firstAfterLoad = 1'b0;
		loadIdx = 0;
		loadLen = 0;
		delivered = 0;
		deliveredInLoad = 0;
		expPc = '0;
		repeat (2) @(posedge clk);
		#1;
		nrst = 1'b1;
		#1;
		checkFlag(decValid, 1'b0, "decValid after reset");
		checkFlag(loadReady, 1'b1, "loadReady after reset");

		loadProgram(64, 1'b0, 200);
		rdyLowPct = 0;
		consumePackets(20, 100, "packets of the first program");

		rdyLowPct = 40;
		consumePackets(30, 300, "packets under back-pressure");

		applyRedirect(frontendPkg::pcTarget, $urandom % 32);
		consumePackets(24, 300, "packets after a target redirect");

		applyRedirect(frontendPkg::pcZero, '0);
		consumePackets(10, 200, "packets after a zero redirect");
		holdFetch(6);
		consumePackets(15, 200, "packets after a hold");

		// target beyond the memory gives faulting packets
		applyRedirect(frontendPkg::pcTarget, 32'h100 + ($urandom % 32'h7fff0000));
		consumePackets(12, 200, "faulting packets");

		applyRedirect(frontendPkg::pcZero, '0);
		consumePackets(8, 200, "packets before the second load");
		loadProgram(64, 1'b1, 600);
		consumePackets(40, 400, "packets of the second program");

		$display("Verification passed");
		$finish;
	end

endmodule
